/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_master_sync
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fails unless it passes"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
sync_pkg.sv
calc_if.sv
timestamp_counter.sv
ts_capture.sv
sync_calc_fsm.sv
delay_offset_alu.sv
master_sync_top.sv
tb_master_sync.sv

/* calc_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface calc_if #(
	parameter int NODES = 4
);
	localparam int NODE_W = sync_pkg::node_w(NODES);

	sync_pkg::alu_op_e         op;
	logic [NODE_W-1:0]         node;
	logic [NODE_W+1:0]         rd_addr; // node*4 + slot
	logic [sync_pkg::TS_W-1:0] rd_data;

	modport fsm (output op, output node, output rd_addr);
	modport mem (input rd_addr, output rd_data);
	modport alu (input op, input node, input rd_data);

endinterface

`default_nettype wire

/* delay_offset_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module delay_offset_alu #(
	parameter int NODES = 4
) (
	input  wire logic                            clk_i,
	input  wire logic                            arst_n_i,
	calc_if.alu                                  alu,
	input  wire logic [sync_pkg::TS_W-1:0]       snap_tx_i,
	input  wire logic [sync_pkg::TS_W-1:0]       snap_rx_i,
	output logic      [NODES*sync_pkg::TS_W-1:0] clock_offsets_o,
	output logic      [NODES*sync_pkg::TS_W-1:0] comm_delays_o
);

	logic [sync_pkg::TS_W-1:0] delay_q;
	logic [sync_pkg::TS_W-1:0] offset_q;
	logic [3:0]                sign_q;   // a in bit 0 after four steps
	logic [sync_pkg::TS_W-1:0] operand;
	logic                      wrap;
	logic [sync_pkg::TS_W-1:0] delay_r  [NODES];
	logic [sync_pkg::TS_W-1:0] offset_r [NODES];

	// Node 0 takes c and d from the frozen local captures
	always_comb begin
		operand = alu.rd_data;
		if (alu.node == '0) begin
			if (alu.op == sync_pkg::OP_T2)
				operand = snap_tx_i;
			else if (alu.op == sync_pkg::OP_T3)
				operand = snap_rx_i;
		end
	end

	assign wrap = (sign_q == 4'b0100) || (sign_q == 4'b0010) || (sign_q == 4'b0111);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			delay_q  <= '0;
			offset_q <= '0;
			sign_q   <= '0;
			for (int n = 0; n < NODES; n++) begin
				delay_r[n]  <= '0;
				offset_r[n] <= '0;
			end
		end else begin
			case (alu.op)
				sync_pkg::OP_T0: begin
					delay_q  <= operand; // Fresh sums per node
					offset_q <= operand;
					sign_q   <= {operand[sync_pkg::SIGN_BIT], sign_q[3:1]};
				end
				sync_pkg::OP_T1: begin
					delay_q  <= delay_q - operand;
					offset_q <= offset_q + operand;
					sign_q   <= {operand[sync_pkg::SIGN_BIT], sign_q[3:1]};
				end
				sync_pkg::OP_T2: begin
					delay_q  <= delay_q - operand;
					offset_q <= offset_q - operand;
					sign_q   <= {operand[sync_pkg::SIGN_BIT], sign_q[3:1]};
				end
				sync_pkg::OP_T3: begin
					delay_q  <= delay_q + operand;
					offset_q <= offset_q - operand;
					sign_q   <= {operand[sync_pkg::SIGN_BIT], sign_q[3:1]};
				end
				sync_pkg::OP_WRAP: begin
					if (wrap)
						offset_q <= offset_q + sync_pkg::WRAP_ADD;
				end
				sync_pkg::OP_STORE: begin
					delay_r[alu.node]  <= delay_q;
					offset_r[alu.node] <= offset_q;
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		for (int n = 0; n < NODES; n++) begin
			comm_delays_o[n*sync_pkg::TS_W +: sync_pkg::TS_W]   = delay_r[n];
			clock_offsets_o[n*sync_pkg::TS_W +: sync_pkg::TS_W] = offset_r[n];
		end
	end

endmodule

`default_nettype wire

/* master_sync_top.sv */
`timescale 1ns/100ps
`default_nettype none

module master_sync_top #(
	parameter int NODES    = 4,
	parameter int MSG_BASE = 32
) (
	input  wire logic                            clk_i,
	input  wire logic                            arst_n_i,
	input  wire logic                            pulse_cycle_i,
	input  wire logic                            snap_tx_i,
	input  wire logic                            snap_rx_i,
	input  wire logic                            rx_we_i,
	input  wire logic [sync_pkg::ADDR_W-1:0]     rx_addr_i,
	input  wire logic [sync_pkg::BYTE_W-1:0]     rx_data_i,
	output logic      [sync_pkg::TS_W-1:0]       local_time_o,
	output logic      [NODES*sync_pkg::TS_W-1:0] clock_offsets_o,
	output logic      [NODES*sync_pkg::TS_W-1:0] comm_delays_o,
	output logic      [NODES-1:0]                rx_ok_o,
	output logic      [NODES-1:0]                sync_ok_o,
	output logic      [NODES-1:0]                slave_rdy_o,
	output logic      [NODES-1:0]                scope_trig_o
);

	logic                      busy;
	logic [sync_pkg::TS_W-1:0] snap_tx;
	logic [sync_pkg::TS_W-1:0] snap_rx;

	calc_if #(.NODES(NODES)) calc ();

	timestamp_counter u_counter (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.snap_tx_i     (snap_tx_i),
		.snap_rx_i     (snap_rx_i),
		.pulse_cycle_i (pulse_cycle_i),
		.local_time_o  (local_time_o),
		.snap_tx_o     (snap_tx),
		.snap_rx_o     (snap_rx)
	);

	ts_capture #(.NODES(NODES), .MSG_BASE(MSG_BASE)) u_capture (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.pulse_cycle_i (pulse_cycle_i),
		.busy_i        (busy),
		.rx_addr_i     (rx_addr_i),
		.rx_data_i     (rx_data_i),
		.rx_we_i       (rx_we_i),
		.mem           (calc.mem),
		.rx_ok_o       (rx_ok_o),
		.sync_ok_o     (sync_ok_o),
		.slave_rdy_o   (slave_rdy_o),
		.scope_trig_o  (scope_trig_o)
	);

	sync_calc_fsm #(.NODES(NODES)) u_fsm (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.pulse_cycle_i (pulse_cycle_i),
		.ctl           (calc.fsm),
		.busy_o        (busy)
	);

	delay_offset_alu #(.NODES(NODES)) u_alu (
		.clk_i           (clk_i),
		.arst_n_i        (arst_n_i),
		.alu             (calc.alu),
		.snap_tx_i       (snap_tx),
		.snap_rx_i       (snap_rx),
		.clock_offsets_o (clock_offsets_o),
		.comm_delays_o   (comm_delays_o)
	);

endmodule

`default_nettype wire

/* sync_calc_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_calc_fsm #(
	parameter int NODES = 4
) (
	input  wire logic clk_i,
	input  wire logic arst_n_i,
	input  wire logic pulse_cycle_i,
	calc_if.fsm       ctl,
	output logic      busy_o
);

	localparam int NODE_W = sync_pkg::node_w(NODES);

	sync_pkg::calc_state_e state_q;
	logic [NODE_W-1:0]     node_q;
	logic [NODE_W+1:0]     base;

	assign base     = {node_q, 2'b00};
	assign busy_o   = (state_q != sync_pkg::S_IDLE);
	assign ctl.node = node_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= sync_pkg::S_IDLE;
			node_q  <= '0;
		end else begin
			case (state_q)
				sync_pkg::S_IDLE: begin
					node_q <= '0;
					if (pulse_cycle_i)
						state_q <= sync_pkg::S_T0;
				end
				sync_pkg::S_T0:   state_q <= sync_pkg::S_T1;
				sync_pkg::S_T1:   state_q <= sync_pkg::S_T2;
				sync_pkg::S_T2:   state_q <= sync_pkg::S_T3;
				sync_pkg::S_T3:   state_q <= sync_pkg::S_WRAP;
				sync_pkg::S_WRAP: state_q <= sync_pkg::S_STORE;
				sync_pkg::S_STORE: begin
					node_q <= node_q + 1'b1;
					if (node_q == NODE_W'(NODES - 1))
						state_q <= sync_pkg::S_IDLE; // Last node done
					else
						state_q <= sync_pkg::S_T0;
				end
				default: state_q <= sync_pkg::S_IDLE;
			endcase
		end
	end

	// Opcode and read slot follow the state
	always_comb begin
		ctl.op      = sync_pkg::OP_NONE;
		ctl.rd_addr = base;
		case (state_q)
			sync_pkg::S_T0: ctl.op = sync_pkg::OP_T0;
			sync_pkg::S_T1: begin
				ctl.op      = sync_pkg::OP_T1;
				ctl.rd_addr = base + 1'b1;
			end
			sync_pkg::S_T2: begin
				ctl.op      = sync_pkg::OP_T2;
				ctl.rd_addr = base - 2'd2; // Slot 2 of previous node
			end
			sync_pkg::S_T3: begin
				ctl.op      = sync_pkg::OP_T3;
				ctl.rd_addr = base - 1'b1;
			end
			sync_pkg::S_WRAP:  ctl.op = sync_pkg::OP_WRAP;
			sync_pkg::S_STORE: ctl.op = sync_pkg::OP_STORE;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* sync_pkg.sv */
`default_nettype none

package sync_pkg;

	// ########################################################################
	// Widths
	// ########################################################################

	localparam int TS_W   = 16; // Timestamp and result width
	localparam int CNT_W  = 15; // Free counter, top timestamp bit stays zero
	localparam int BYTE_W = 8;
	localparam int ADDR_W = 8;

	// ########################################################################
	// Receive buffer layout, per node frame
	// ########################################################################

	localparam int MSG_LEN   = 16;
	localparam int FLAGS_OFS = 2; // High byte follows at +1
	localparam int TS_OFS    = 4; // Slot k: low at TS_OFS+2k, high at TS_OFS+2k+1

	// Sign history and offset correction
	localparam int SIGN_BIT = 14;
	localparam logic [TS_W-1:0] WRAP_ADD = 16'h8000;

	// Node index width, kept at least one bit wide
	function automatic int node_w(input int nodes);
		return (nodes > 1) ? $clog2(nodes) : 1;
	endfunction

	typedef enum logic [2:0] {
		OP_NONE,
		OP_T0,
		OP_T1,
		OP_T2,
		OP_T3,
		OP_WRAP,
		OP_STORE
	} alu_op_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_T0,
		S_T1,
		S_T2,
		S_T3,
		S_WRAP,
		S_STORE
	} calc_state_e;

endpackage

`default_nettype wire

/* tb_master_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_master_sync;

	localparam int NODES    = 4;
	localparam int MSG_BASE = 32;
	localparam int TW       = sync_pkg::TS_W;
	localparam int SB       = sync_pkg::SIGN_BIT;
	localparam int CALC     = 6 * NODES + 1; // Cycles until all results are final

	logic                    clk_i, arst_n_i, pulse_cycle_i, snap_tx_i, snap_rx_i, rx_we_i;
	logic [7:0]              rx_addr_i, rx_data_i;
	logic [TW-1:0]           local_time_o;
	logic [NODES*TW-1:0]     clock_offsets_o, comm_delays_o;
	logic [NODES-1:0]        rx_ok_o, sync_ok_o, slave_rdy_o, scope_trig_o;

	logic [TW-1:0]    ts_mem [NODES*4]; // Expected slot contents by node*4 + slot
	logic [15:0]      flag_mdl [NODES];
	logic [NODES-1:0] ts_done;          // Timestamps written since the last pulse
	logic [TW-1:0]    exp_tx, exp_rx;
	logic [4*NODES-1:0] held;
	integer           seed;
	int               errors, err_mark, tests, failed;

	master_sync_top DUT (.*);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	// Counter steps by one and wraps at 2^15
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$past(arst_n_i) |-> local_time_o == (($past(local_time_o) + 16'd1) & 16'h7FFF))
	else begin
		$display("MISMATCH at %0t: local_time_o did not step by one", $time);
		errors++;
	end

	// ########################################################################
	// Stimulus and reference model
	// ########################################################################

	task automatic next_cycle();
		@(posedge clk_i);
		#2;
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
			next_cycle();
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic write_byte(input int addr, input logic [7:0] data);
		rx_we_i   = 1'b1;
		rx_addr_i = 8'(addr);
		rx_data_i = data;
		next_cycle();
		rx_we_i = 1'b0;
	endtask

	task automatic write_frame(input int n, input logic [15:0] flags, input bit with_ts);
		int base;
		base = MSG_BASE + n * sync_pkg::MSG_LEN;
		write_byte(base + sync_pkg::FLAGS_OFS, flags[7:0]);
		write_byte(base + sync_pkg::FLAGS_OFS + 1, flags[15:8]);
		flag_mdl[n] = flags;
		if (with_ts) begin
			for (int k = 0; k < 4; k++) begin
				write_byte(base + sync_pkg::TS_OFS + 2 * k, ts_mem[n * 4 + k][7:0]);
				write_byte(base + sync_pkg::TS_OFS + 2 * k + 1, ts_mem[n * 4 + k][15:8]);
			end
			ts_done[n] = 1'b1;
		end
	endtask

	task automatic strobe(input bit tx);
		if (tx) begin
			snap_tx_i = 1'b1;
			exp_tx    = local_time_o; // Value taken at the coming edge
		end else begin
			snap_rx_i = 1'b1;
			exp_rx    = local_time_o;
		end
		next_cycle();
		snap_tx_i = 1'b0;
		snap_rx_i = 1'b0;
	endtask

	// Accepted pulse with the status compared one cycle later
	task automatic pulse_cycle();
		logic [NODES-1:0] ok, sync, rdy, trig;
		logic             chain;
		chain = 1'b1;
		for (int n = 0; n < NODES; n++) begin
			chain   = chain & ts_done[n];
			ok[n]   = chain;
			sync[n] = ok[n] & flag_mdl[n][0];
			rdy[n]  = sync[n] & flag_mdl[n][1];
			trig[n] = ok[n] & flag_mdl[n][2];
		end
		pulse_cycle_i = 1'b1;
		next_cycle();
		pulse_cycle_i = 1'b0;
		ts_done = '0;
		for (int n = 0; n < NODES; n++)
			flag_mdl[n] = '0;
		check_value("rx_ok_o", 32'(rx_ok_o), 32'(ok));
		check_value("sync_ok_o", 32'(sync_ok_o), 32'(sync));
		check_value("slave_rdy_o", 32'(slave_rdy_o), 32'(rdy));
		check_value("scope_trig_o", 32'(scope_trig_o), 32'(trig));
	endtask

	task automatic check_results();
		logic [TW-1:0] a, b, c, d, dly, ofs;
		logic [3:0]    hist;
		for (int n = 0; n < NODES; n++) begin
			a    = ts_mem[n * 4];
			b    = ts_mem[n * 4 + 1];
			c    = (n == 0) ? exp_tx : ts_mem[n * 4 - 2];
			d    = (n == 0) ? exp_rx : ts_mem[n * 4 - 1];
			hist = {d[SB], c[SB], b[SB], a[SB]};
			dly  = a - b - c + d;
			ofs  = a + b - c - d;
			if (hist == 4'b0100 || hist == 4'b0010 || hist == 4'b0111)
				ofs = ofs + 16'h8000;
			check_value($sformatf("delay[%0d]", n), 32'(comm_delays_o[n*TW +: TW]), 32'(dly));
			check_value($sformatf("offset[%0d]", n), 32'(clock_offsets_o[n*TW +: TW]),
				32'(ofs));
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == err_mark) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("Test %0d %s: %0d errors", tests, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// ########################################################################
	// Test sequence
	// ########################################################################

	initial begin
		seed = 21278;
		{errors, err_mark, tests, failed} = '0;
		{arst_n_i, pulse_cycle_i, snap_tx_i, snap_rx_i, rx_we_i} = '0;
		rx_addr_i = '0;
		rx_data_i = '0;
		ts_done   = '0;
		exp_tx    = '0;
		exp_rx    = '0;
		for (int n = 0; n < NODES; n++)
			flag_mdl[n] = '0;
		for (int i = 0; i < NODES * 4; i++)
			ts_mem[i] = 16'($random(seed));
		wait_cycles(3);
		arst_n_i = 1'b1;

		for (int n = 0; n < NODES; n++)
			write_frame(n, 16'h0000, 1'b1);
		strobe(1'b1);
		wait_cycles(5);
		strobe(1'b0);
		wait_cycles(2);
		pulse_cycle();
		wait_cycles(CALC);
		check_results();
		finish_test("counter and captures");

		for (int n = 0; n < NODES; n++)
			write_frame(n, 16'h0000, 1'b1);
		pulse_cycle();
		check_value("rx_ok_o full", 32'(rx_ok_o), 32'({NODES{1'b1}}));
		wait_cycles(CALC);
		for (int n = 0; n < NODES; n++)
			write_frame(n, 16'h0000, n != 1); // Node 1 sends flags only
		pulse_cycle();
		check_value("rx_ok_o broken chain", 32'(rx_ok_o), 32'h1);
		wait_cycles(CALC);
		check_results();
		finish_test("readiness chain");

		write_frame(0, 16'h0007, 1'b1);
		write_frame(1, 16'h0001, 1'b1);
		write_frame(2, 16'h0104, 1'b1);
		write_frame(3, 16'h0002, 1'b1); // Ready without sync
		pulse_cycle();
		wait_cycles(CALC);
		finish_test("status flags");

		for (int i = 0; i < NODES * 4; i++)
			ts_mem[i] = 16'($random(seed));
		{ts_mem[4][SB], ts_mem[5][SB], ts_mem[2][SB], ts_mem[3][SB]}     = 4'b0010;
		{ts_mem[8][SB], ts_mem[9][SB], ts_mem[6][SB], ts_mem[7][SB]}     = 4'b0100;
		{ts_mem[12][SB], ts_mem[13][SB], ts_mem[10][SB], ts_mem[11][SB]} = 4'b1110;
		for (int n = 0; n < NODES; n++)
			write_frame(n, 16'(n), 1'b1);
		pulse_cycle();
		wait_cycles(CALC);
		check_results();
		finish_test("delay and offset");

		for (int n = 0; n < NODES; n++)
			write_frame(n, 16'h0007, 1'b1);
		pulse_cycle();
		wait_cycles(2);
		held = {rx_ok_o, sync_ok_o, slave_rdy_o, scope_trig_o};
		pulse_cycle_i = 1'b1; // Lands while the calculation runs
		next_cycle();
		pulse_cycle_i = 1'b0;
		check_value("status after busy pulse",
			32'({rx_ok_o, sync_ok_o, slave_rdy_o, scope_trig_o}), 32'(held));
		wait_cycles(CALC);
		check_results();
		pulse_cycle();
		wait_cycles(CALC);
		check_results();
		finish_test("pulse handling");

		$display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* timestamp_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module timestamp_counter (
	input  wire logic                      clk_i,
	input  wire logic                      arst_n_i,
	input  wire logic                      snap_tx_i,
	input  wire logic                      snap_rx_i,
	input  wire logic                      pulse_cycle_i,
	output logic      [sync_pkg::TS_W-1:0] local_time_o,
	output logic      [sync_pkg::TS_W-1:0] snap_tx_o,
	output logic      [sync_pkg::TS_W-1:0] snap_rx_o
);

	logic [sync_pkg::CNT_W-1:0] cnt_q;
	logic [sync_pkg::TS_W-1:0]  tx_cap_q;
	logic [sync_pkg::TS_W-1:0]  rx_cap_q;

	assign local_time_o = {{(sync_pkg::TS_W - sync_pkg::CNT_W){1'b0}}, cnt_q};

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q     <= '0;
			tx_cap_q  <= '0;
			rx_cap_q  <= '0;
			snap_tx_o <= '0;
			snap_rx_o <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1; // Wraps at 2^15
			if (snap_tx_i)
				tx_cap_q <= local_time_o;
			if (snap_rx_i)
				rx_cap_q <= local_time_o;
			// Freeze for the calculation of this cycle
			if (pulse_cycle_i) begin
				snap_tx_o <= tx_cap_q;
				snap_rx_o <= rx_cap_q;
			end
		end
	end

endmodule

`default_nettype wire

/* ts_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module ts_capture #(
	parameter int NODES    = 4,
	parameter int MSG_BASE = 32
) (
	input  wire logic                        clk_i,
	input  wire logic                        arst_n_i,
	input  wire logic                        pulse_cycle_i,
	input  wire logic                        busy_i,
	input  wire logic [sync_pkg::ADDR_W-1:0] rx_addr_i,
	input  wire logic [sync_pkg::BYTE_W-1:0] rx_data_i,
	input  wire logic                        rx_we_i,
	calc_if.mem                              mem,
	output logic      [NODES-1:0]            rx_ok_o,
	output logic      [NODES-1:0]            sync_ok_o,
	output logic      [NODES-1:0]            slave_rdy_o,
	output logic      [NODES-1:0]            scope_trig_o
);

	localparam int SLOT_W = sync_pkg::node_w(NODES) + 2;

	logic [sync_pkg::BYTE_W-1:0] ts_lo [NODES*4];
	logic [sync_pkg::BYTE_W-1:0] ts_hi [NODES*4];
	logic [15:0]                 flags_q [NODES];

	logic [NODES-1:0]  rdy1_q;
	logic [NODES-1:0]  rdy2_q;
	logic [NODES-1:0]  rdy1_d;
	logic [NODES-1:0]  rdy2_d;
	logic [NODES-1:0]  prev_ok;
	logic [NODES-1:0]  rx_both;
	logic [NODES-1:0]  flag_lo_we;
	logic [NODES-1:0]  flag_hi_we;
	logic              ts_lo_we;
	logic              ts_hi_we;
	logic [SLOT_W-1:0] wr_slot;
	logic              accept;

	assign accept  = pulse_cycle_i & ~busy_i;
	assign rx_both = rdy1_q & rdy2_q;

	assign mem.rd_data = {ts_hi[mem.rd_addr], ts_lo[mem.rd_addr]};

	// ########################################################################
	// Address decode and readiness chain
	// ########################################################################

	always_comb begin
		prev_ok[0] = 1'b1;
		for (int n = 1; n < NODES; n++)
			prev_ok[n] = rdy1_q[n-1] & rdy2_q[n-1]; // Previous node complete

		rdy1_d     = rdy1_q;
		rdy2_d     = rdy2_q;
		ts_lo_we   = 1'b0;
		ts_hi_we   = 1'b0;
		flag_lo_we = '0;
		flag_hi_we = '0;
		wr_slot    = '0;

		for (int n = 0; n < NODES; n++) begin
			if (int'(rx_addr_i) == MSG_BASE + n * sync_pkg::MSG_LEN + sync_pkg::FLAGS_OFS)
				flag_lo_we[n] = rx_we_i;
			if (int'(rx_addr_i) == MSG_BASE + n * sync_pkg::MSG_LEN + sync_pkg::FLAGS_OFS + 1)
				flag_hi_we[n] = rx_we_i;

			for (int k = 0; k < 4; k++) begin
				if (int'(rx_addr_i) ==
						MSG_BASE + n * sync_pkg::MSG_LEN + sync_pkg::TS_OFS + 2 * k) begin
					ts_lo_we = rx_we_i;
					wr_slot  = SLOT_W'(n * 4 + k);
					if (rx_we_i && prev_ok[n])
						rdy1_d[n] = 1'b1;
				end
				if (int'(rx_addr_i) ==
						MSG_BASE + n * sync_pkg::MSG_LEN + sync_pkg::TS_OFS + 2 * k + 1) begin
					ts_hi_we = rx_we_i;
					wr_slot  = SLOT_W'(n * 4 + k);
					if (rx_we_i && prev_ok[n] && rdy1_q[n])
						rdy2_d[n] = 1'b1; // Only after a low byte
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (ts_lo_we)
			ts_lo[wr_slot] <= rx_data_i;
		if (ts_hi_we)
			ts_hi[wr_slot] <= rx_data_i;
	end

	// ########################################################################
	// Flags and status latch
	// ########################################################################

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdy1_q       <= '0;
			rdy2_q       <= '0;
			rx_ok_o      <= '0;
			sync_ok_o    <= '0;
			slave_rdy_o  <= '0;
			scope_trig_o <= '0;
			for (int n = 0; n < NODES; n++)
				flags_q[n] <= '0;
		end else if (accept) begin
			rx_ok_o <= rx_both;
			for (int n = 0; n < NODES; n++) begin
				sync_ok_o[n]    <= rx_both[n] & flags_q[n][0];
				slave_rdy_o[n]  <= rx_both[n] & flags_q[n][0] & flags_q[n][1];
				scope_trig_o[n] <= rx_both[n] & flags_q[n][2];
				flags_q[n]      <= '0;
			end
			rdy1_q <= '0; // New cycle starts empty
			rdy2_q <= '0;
		end else begin
			rdy1_q <= rdy1_d;
			rdy2_q <= rdy2_d;
			for (int n = 0; n < NODES; n++) begin
				if (flag_lo_we[n])
					flags_q[n][7:0] <= rx_data_i;
				if (flag_hi_we[n])
					flags_q[n][15:8] <= rx_data_i;
			end
		end
	end

endmodule

`default_nettype wire
